//--- Makefile
TOP := linebuf_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal \
		-f compile.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

//--- compile.f
+incdir+include
hdl/linebuf_shape_pkg.sv
hdl/linebuf_ctrl_pkg.sv
hdl/linebuf_ctrl.sv
hdl/linebuf_mem.sv
hdl/linebuf_window.sv
hdl/linebuf_top.sv
testbench/linebuf_tb.sv

//--- hdl/linebuf_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

`include "linebuf_cfg.svh"

module linebuf_ctrl (
  input  wire                             clk,
  input  wire                             xrst,
  input  wire                             req,
  input  wire linebuf_shape_pkg::shape_t  shape,
  output logic                            ack,
  output logic                            pix_ready,
  output linebuf_ctrl_pkg::buf_wr_t       wr,
  output linebuf_ctrl_pkg::buf_rd_t       rd,
  output linebuf_ctrl_pkg::win_flags_t    flags
);

  import linebuf_shape_pkg::*;
  import linebuf_ctrl_pkg::*;

  localparam int FLAG_DLY = 3;

  typedef enum logic [1:0] {
    S_WAIT,
    S_CHARGE,
    S_ACTIVE
  } state_t;

  typedef struct packed {
    len_t      row;
    line_idx_t mem;
  } pos_t;

  state_t     state;
  shape_t     shp;
  len_t       pw;
  len_t       hp;

  len_t       col_q;
  len_t       col_nxt;
  len_t       row_q;
  line_idx_t  mem_q;
  len_t       sx_q;
  len_t       sy_q;

  logic       row_end;
  logic       charge_end;
  logic       active_end;
  logic       in_img;
  logic       valid_now;
  logic [2:0] ack_d;

  pos_t       pos_d [`LB_RD_LAT];
  pos_t       pos_rd;
  win_flags_t flag_now;
  win_flags_t flag_d [FLAG_DLY];

  // ===================================================================
  // request and state
  // ===================================================================

  assign ack = state == S_WAIT && ack_d[2];

  assign pw = padded_size(shp.width, shp.pad);
  assign hp = shp.height + shp.pad;

  assign row_end    = col_q == pw - 1'b1;
  assign charge_end = row_end && row_q == shp.kern - shp.pad - 1'b1;
  assign active_end = row_end && row_q == hp;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state <= S_WAIT;
    end else begin
      case (state)
        S_WAIT: begin
          if (req && ack) begin
            state <= S_CHARGE;
          end
        end
        S_CHARGE: begin
          if (charge_end) begin
            state <= S_ACTIVE;
          end
        end
        S_ACTIVE: begin
          if (active_end) begin
            state <= S_WAIT;
          end
        end
        default: begin
          state <= S_WAIT;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      shp <= '0;
    end else if (state == S_WAIT && req && ack) begin
      shp <= shape;
    end
  end

  // ack needs three idle cycles
  always_ff @(posedge clk) begin
    if (!xrst) begin
      ack_d <= '0;
    end else begin
      ack_d <= {ack_d[1:0], state == S_WAIT};
    end
  end

  // ===================================================================
  // position counters
  // ===================================================================

  assign col_nxt = row_end ? '0 : col_q + 1'b1;

  // sx and sy restart where the first window column and row begin
  always_ff @(posedge clk) begin
    if (!xrst || state == S_WAIT) begin
      col_q <= '0;
      row_q <= '0;
      mem_q <= '0;
      sx_q  <= '0;
      sy_q  <= '0;
    end else begin
      col_q <= col_nxt;
      if (col_nxt == shp.kern - 1'b1 || sx_q == shp.strid - 1'b1) begin
        sx_q <= '0;
      end else begin
        sx_q <= sx_q + 1'b1;
      end
      if (row_end) begin
        row_q <= row_q + 1'b1;
        if (mem_q == line_idx_t'(`LB_BUFLINE - 1)) begin
          mem_q <= '0;
        end else begin
          mem_q <= mem_q + 1'b1;
        end
        if (row_q + 1'b1 == shp.kern - shp.pad || sy_q == shp.strid - 1'b1) begin
          sy_q <= '0;
        end else begin
          sy_q <= sy_q + 1'b1;
        end
      end
    end
  end

  // read side sees the counters after the memory latency
  always_ff @(posedge clk) begin
    if (!xrst) begin
      for (int i = 0; i < `LB_RD_LAT; i++) begin
        pos_d[i] <= '0;
      end
    end else begin
      pos_d[0] <= '{row: row_q, mem: mem_q};
      for (int i = 1; i < `LB_RD_LAT; i++) begin
        pos_d[i] <= pos_d[i-1];
      end
    end
  end

  assign pos_rd = pos_d[`LB_RD_LAT-1];

  // ===================================================================
  // write and read select
  // ===================================================================

  assign in_img = row_q < shp.height
               && col_q >= shp.pad
               && col_q < shp.width + shp.pad;

  assign pix_ready = state != S_WAIT && in_img;

  // one line per row, bottom pad rows stored as zeros
  always_ff @(posedge clk) begin
    if (!xrst || state == S_WAIT) begin
      wr <= '0;
    end else begin
      wr.we   <= row_q < hp;
      wr.wcol <= in_img;
      wr.wsel <= row_q < hp ? line_sel_t'(mem_q) + 1'b1 : '0;
      wr.addr <= col_addr_t'(col_q);
    end
  end

  // kernel row i holds frame row (row - MAXFIL + i)
  // top pad rows are never written, so the mask covers them
  always_ff @(posedge clk) begin
    if (!xrst) begin
      rd <= '0;
    end else begin
      rd.rsel <= line_idx_t'((int'(pos_rd.mem) + `LB_BUFLINE - `LB_MAXFIL) % `LB_BUFLINE);
      for (int i = 0; i < `LB_MAXFIL; i++) begin
        rd.rrow[i] <= i + shp.kern >= `LB_MAXFIL
                   && pos_rd.row + i >= `LB_MAXFIL
                   && pos_rd.row + i < shp.height + `LB_MAXFIL;
      end
    end
  end

  // ===================================================================
  // window strobes
  // ===================================================================

  assign valid_now = state == S_ACTIVE
                  && col_q >= shp.kern - 1'b1
                  && sx_q == '0
                  && sy_q == '0;

  // stop when no further stride fits in either direction
  assign flag_now = '{
    start: valid_now && row_q == shp.kern - shp.pad && col_q == shp.kern - 1'b1,
    valid: valid_now,
    stop:  valid_now && col_q + shp.strid >= pw && row_q + shp.strid > hp
  };

  always_ff @(posedge clk) begin
    if (!xrst) begin
      for (int i = 0; i < FLAG_DLY; i++) begin
        flag_d[i] <= '0;
      end
    end else begin
      flag_d[0] <= flag_now;
      for (int i = 1; i < FLAG_DLY; i++) begin
        flag_d[i] <= flag_d[i-1];
      end
    end
  end

  assign flags = flag_d[FLAG_DLY-1];

endmodule

`default_nettype wire

//--- hdl/linebuf_ctrl_pkg.sv
`default_nettype none

`include "linebuf_cfg.svh"

package linebuf_ctrl_pkg;

  typedef logic [$clog2(`LB_BUFLINE)-1:0]   line_idx_t;
  typedef logic [$clog2(`LB_BUFLINE+1)-1:0] line_sel_t;
  typedef logic [$clog2(`LB_MAXIMG)-1:0]    col_addr_t;

  // write port of the line ring
  // wsel of zero selects no line
  typedef struct packed {
    logic      we;
    logic      wcol;
    line_sel_t wsel;
    col_addr_t addr;
  } buf_wr_t;

  typedef struct packed {
    line_idx_t             rsel;
    logic [`LB_MAXFIL-1:0] rrow;
  } buf_rd_t;

  typedef struct packed {
    logic start;
    logic valid;
    logic stop;
  } win_flags_t;

  // oldest row and oldest column sit at index 0
  typedef linebuf_shape_pkg::pixel_t [`LB_MAXFIL-1:0][`LB_MAXFIL-1:0] window_t;

endpackage

`default_nettype wire

//--- hdl/linebuf_mem.sv
`default_nettype none
`timescale 1ns/1ps

`include "linebuf_cfg.svh"

module linebuf_mem (
  input  wire                                           clk,
  input  wire                                           xrst,
  input  wire linebuf_shape_pkg::pixel_t                pix,
  input  wire                                           pix_ready,
  input  wire linebuf_ctrl_pkg::buf_wr_t                wr,
  output wire linebuf_shape_pkg::pixel_t [`LB_BUFLINE-1:0] lines
);

  import linebuf_shape_pkg::*;
  import linebuf_ctrl_pkg::*;

  pixel_t pix_q;
  pixel_t wdata;

  always_ff @(posedge clk) begin
    if (pix_ready) begin
      pix_q <= pix;
    end
  end

  // pad columns go in as zero
  assign wdata = wr.wcol ? pix_q : '0;

  // ===================================================================
  // line ring
  // ===================================================================

  for (genvar l = 0; l < `LB_BUFLINE; l++) begin : g_line
    pixel_t ram  [`LB_MAXIMG];
    pixel_t rdat [`LB_RD_LAT];

    always_ff @(posedge clk) begin
      if (xrst && wr.we && wr.wsel == line_sel_t'(l + 1)) begin
        ram[wr.addr] <= wdata;
      end
    end

    // all lines read at the write column
    always_ff @(posedge clk) begin
      rdat[0] <= ram[wr.addr];
      for (int i = 1; i < `LB_RD_LAT; i++) begin
        rdat[i] <= rdat[i-1];
      end
    end

    assign lines[l] = rdat[`LB_RD_LAT-1];
  end

endmodule

`default_nettype wire

//--- hdl/linebuf_shape_pkg.sv
`default_nettype none

`include "linebuf_cfg.svh"

package linebuf_shape_pkg;

  typedef logic [`LB_LWIDTH-1:0] len_t;

  // frame geometry
  // sampled once per frame when the request is taken
  typedef struct packed {
    len_t height;
    len_t width;
    len_t kern;
    len_t strid;
    len_t pad;
  } shape_t;

  typedef logic [`LB_DWIDTH-1:0] pixel_t;

  // size with pad on both sides
  function automatic len_t padded_size(input len_t size, input len_t pad);
    return size + (pad << 1);
  endfunction

endpackage

`default_nettype wire

//--- hdl/linebuf_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "linebuf_cfg.svh"

module linebuf_top (
  input  wire                             clk,
  input  wire                             xrst,
  input  wire                             req,
  input  wire linebuf_shape_pkg::shape_t  shape,
  input  wire linebuf_shape_pkg::pixel_t  pix,
  output logic                            ack,
  output logic                            pix_ready,
  output linebuf_ctrl_pkg::window_t       win,
  output linebuf_ctrl_pkg::win_flags_t    flags
);

  import linebuf_shape_pkg::*;
  import linebuf_ctrl_pkg::*;

  buf_wr_t                  wr;
  buf_rd_t                  rd;
  win_flags_t               ctrl_flags;
  pixel_t [`LB_BUFLINE-1:0] lines;
  win_flags_t               flag_d [`LB_RD_LAT];

  linebuf_ctrl i_linebuf_ctrl (
    .clk       (clk),
    .xrst      (xrst),
    .req       (req),
    .shape     (shape),
    .ack       (ack),
    .pix_ready (pix_ready),
    .wr        (wr),
    .rd        (rd),
    .flags     (ctrl_flags)
  );

  linebuf_mem i_linebuf_mem (
    .clk       (clk),
    .xrst      (xrst),
    .pix       (pix),
    .pix_ready (pix_ready),
    .wr        (wr),
    .lines     (lines)
  );

  linebuf_window i_linebuf_window (
    .clk   (clk),
    .xrst  (xrst),
    .lines (lines),
    .rd    (rd),
    .win   (win)
  );

  // window path is longer by the memory latency
  always_ff @(posedge clk) begin
    if (!xrst) begin
      for (int i = 0; i < `LB_RD_LAT; i++) begin
        flag_d[i] <= '0;
      end
    end else begin
      flag_d[0] <= ctrl_flags;
      for (int i = 1; i < `LB_RD_LAT; i++) begin
        flag_d[i] <= flag_d[i-1];
      end
    end
  end

  assign flags = flag_d[`LB_RD_LAT-1];

endmodule

`default_nettype wire

//--- hdl/linebuf_window.sv
`default_nettype none
`timescale 1ns/1ps

`include "linebuf_cfg.svh"

module linebuf_window (
  input  wire                                              clk,
  input  wire                                              xrst,
  input  wire linebuf_shape_pkg::pixel_t [`LB_BUFLINE-1:0] lines,
  input  wire linebuf_ctrl_pkg::buf_rd_t                   rd,
  output linebuf_ctrl_pkg::window_t                        win
);

  import linebuf_shape_pkg::*;

  pixel_t [`LB_MAXFIL-1:0] col_sel;
  pixel_t [`LB_MAXFIL-1:0] col_q;

  // ===================================================================
  // rotate and mask
  // ===================================================================

  // kernel row r comes from line rsel + r, wrapped around the ring
  always_comb begin
    int idx;
    for (int r = 0; r < `LB_MAXFIL; r++) begin
      idx = int'(rd.rsel) + r;
      if (idx >= `LB_BUFLINE) begin
        idx = idx - `LB_BUFLINE;
      end
      col_sel[r] = rd.rrow[r] ? lines[idx] : '0;
    end
  end

  // ===================================================================
  // column shift
  // ===================================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      col_q <= '0;
    end else begin
      col_q <= col_sel;
    end
  end

  // newest column enters at the top index
  always_ff @(posedge clk) begin
    if (!xrst) begin
      win <= '0;
    end else begin
      for (int r = 0; r < `LB_MAXFIL; r++) begin
        for (int c = 0; c < `LB_MAXFIL - 1; c++) begin
          win[r][c] <= win[r][c+1];
        end
        win[r][`LB_MAXFIL-1] <= col_q[r];
      end
    end
  end

endmodule

`default_nettype wire

//--- include/linebuf_cfg.svh
`ifndef LINEBUF_CFG_SVH
`define LINEBUF_CFG_SVH

// largest kernel, rows and columns
`define LB_MAXFIL  3
// longest padded line
`define LB_MAXIMG  32
`define LB_DWIDTH  16
`define LB_LWIDTH  8

// one spare line so the row being written never overlaps a kernel row
`define LB_BUFLINE (`LB_MAXFIL + 1)

`define LB_RD_LAT  1

`endif

//--- testbench/linebuf_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "linebuf_cfg.svh"

module linebuf_tb;

  import linebuf_shape_pkg::*;
  import linebuf_ctrl_pkg::*;

  localparam int NFRAME = 2;
  localparam int MAXH   = 8;
  localparam int MAXW   = 8;

  logic       clk = 1'b0;
  logic       xrst;
  logic       req;
  shape_t     shape;
  pixel_t     pix;
  logic       ack;
  logic       pix_ready;
  window_t    win;
  win_flags_t flags;

  shape_t      shapes [NFRAME];
  pixel_t      img [MAXH][MAXW];
  window_t     exp_q [$];
  win_flags_t  expf_q [$];
  int          seed;
  int          n_valid = 0;
  int          n_start = 0;
  int          n_stop  = 0;
  int unsigned cycles  = 0;
  int unsigned cycle_limit = 1000;

  always #2 clk = ~clk;

  linebuf_top i_linebuf_top (
    .clk       (clk),
    .xrst      (xrst),
    .req       (req),
    .shape     (shape),
    .pix       (pix),
    .ack       (ack),
    .pix_ready (pix_ready),
    .win       (win),
    .flags     (flags)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  // ===================================================================
  // reference model
  // ===================================================================

  // zero outside the real image
  function automatic pixel_t padded_pixel(input shape_t s, input int py, input int px);
    if (py < int'(s.pad) || py >= int'(s.height) + int'(s.pad)
        || px < int'(s.pad) || px >= int'(s.width) + int'(s.pad)) begin
      return '0;
    end
    return img[py - int'(s.pad)][px - int'(s.pad)];
  endfunction

  function automatic int frame_cycles(input shape_t s);
    return (int'(s.height) + 2 * int'(s.pad) + 1) * (int'(s.width) + 2 * int'(s.pad)) + 16;
  endfunction

  task automatic fill_image(input shape_t s);
    for (int y = 0; y < int'(s.height); y++) begin
      for (int x = 0; x < int'(s.width); x++) begin
        img[y][x] = pixel_t'($random(seed));
      end
    end
  endtask

  // one window per stride position in raster order
  task automatic build_expected(input shape_t s, output int n_exp);
    int         ho;
    int         wo;
    window_t    w;
    win_flags_t f;
    ho = (int'(s.height) + 2 * int'(s.pad) - int'(s.kern)) / int'(s.strid) + 1;
    wo = (int'(s.width) + 2 * int'(s.pad) - int'(s.kern)) / int'(s.strid) + 1;
    n_exp = ho * wo;
    for (int oy = 0; oy < ho; oy++) begin
      for (int ox = 0; ox < wo; ox++) begin
        for (int r = 0; r < `LB_MAXFIL; r++) begin
          for (int c = 0; c < `LB_MAXFIL; c++) begin
            w[r][c] = padded_pixel(s, oy * int'(s.strid) + r, ox * int'(s.strid) + c);
          end
        end
        f.start = oy == 0 && ox == 0;
        f.valid = 1'b1;
        f.stop  = oy == ho - 1 && ox == wo - 1;
        exp_q.push_back(w);
        expf_q.push_back(f);
      end
    end
  endtask

  // ===================================================================
  // frame stimulus
  // ===================================================================

  task automatic run_frame(input shape_t s);
    int n_exp;
    int npix;
    int fed;
    int base_valid;
    int base_start;
    int base_stop;
    fill_image(s);
    build_expected(s, n_exp);
    npix = int'(s.height) * int'(s.width);
    fed = 0;
    base_valid = n_valid;
    base_start = n_start;
    base_stop  = n_stop;
    while (!ack) begin
      @(posedge clk);
    end
    shape <= s;
    req   <= 1'b1;
    pix   <= img[0][0];
    @(posedge clk);
    req <= 1'b0;
    // pix always holds the next pixel not yet taken
    do begin
      @(posedge clk);
      if (pix_ready) begin
        assert (fed < npix) else abort_run("pix_ready stayed high after the last pixel");
        fed++;
        if (fed < npix) begin
          pix <= img[fed / int'(s.width)][fed % int'(s.width)];
        end
      end
    end while (!ack);
    @(posedge clk);
    assert (fed == npix)
      else abort_run($sformatf("ERR pix_ready count got %h exp %h", fed, npix));
    assert (n_valid - base_valid == n_exp)
      else abort_run($sformatf("ERR flags.valid count got %h exp %h",
                               n_valid - base_valid, n_exp));
    assert (n_start - base_start == 1)
      else abort_run($sformatf("ERR flags.start count got %h exp %h",
                               n_start - base_start, 1));
    assert (n_stop - base_stop == 1)
      else abort_run($sformatf("ERR flags.stop count got %h exp %h",
                               n_stop - base_stop, 1));
  endtask

  initial begin
    seed = 32'h25ff_b47c;
    xrst = 1'b0;
    req = 1'b0;
    shape = '0;
    pix = '0;
    shapes[0] = '{height: 8'd3, width: 8'd3, kern: 8'd3, strid: 8'd1, pad: 8'd1};
    shapes[1] = '{height: 8'd3, width: 8'd3, kern: 8'd3, strid: 8'd2, pad: 8'd0};
    cycle_limit = 5 + 32;
    for (int f = 0; f < NFRAME; f++) begin
      cycle_limit += frame_cycles(shapes[f]);
    end
    repeat (5) @(posedge clk);
    xrst <= 1'b1;
    for (int f = 0; f < NFRAME; f++) begin
      run_frame(shapes[f]);
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

  // ===================================================================
  // checks
  // ===================================================================

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      abort_run($sformatf("timeout, the frames did not finish within %0d cycles", cycle_limit));
    end
  end

  // window and strobes against the reference in order
  always @(posedge clk) begin
    window_t    exp_win;
    win_flags_t exp_flg;
    if (xrst && flags.valid) begin
      assert (exp_q.size() != 0) else abort_run("flags.valid came with no window left to expect");
      exp_win = exp_q.pop_front();
      exp_flg = expf_q.pop_front();
      n_valid++;
      for (int r = 0; r < `LB_MAXFIL; r++) begin
        for (int c = 0; c < `LB_MAXFIL; c++) begin
          assert (win[r][c] == exp_win[r][c])
            else abort_run($sformatf("ERR win[%0d][%0d] got %h exp %h",
                                     r, c, win[r][c], exp_win[r][c]));
        end
      end
      assert (flags == exp_flg)
        else abort_run($sformatf("ERR flags got %h exp %h", flags, exp_flg));
    end
    if (xrst && flags.start) begin
      n_start++;
    end
    if (xrst && flags.stop) begin
      n_stop++;
    end
  end

  assert property (@(posedge clk) !xrst |=> (flags == '0 && !ack && !pix_ready))
    else abort_run("outputs not idle after a reset cycle");

  assert property (@(posedge clk) disable iff (!xrst) (req && ack) |=> !ack)
    else abort_run("ack did not fall after the request was taken");

  assert property (@(posedge clk) disable iff (!xrst) ack |-> !pix_ready)
    else abort_run("pix_ready was high while ack was high");

  assert property (@(posedge clk) disable iff (!xrst) flags.start |-> flags.valid)
    else abort_run("flags.start came without flags.valid");

  assert property (@(posedge clk) disable iff (!xrst) flags.stop |-> flags.valid)
    else abort_run("flags.stop came without flags.valid");

endmodule

`default_nettype wire
